// ==== build.f ====
+incdir+src
src/cu_pkg.sv
src/cu_input_stage.sv
src/cu_response_router.sv
src/cu_read_arbiter.sv
src/cu_command_output.sv
src/cu_job_tracker.sv
src/cu_control.sv
dv/cu_control_assert.sv
dv/cu_control_tb.sv

// ==== dv/cu_control_assert.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cu_macros.svh"

module cu_control_assert (
	input logic                       clock,
	input logic                       rstn,
	input logic [`CU_CONFIG_BITS-1:0] config_word,
	input cu_pkg::cu_status_t         read_status,
	input cu_pkg::cu_status_t         write_status,
	input cu_pkg::cu_cmd_t            vertex_cmd,
	input cu_pkg::cu_cmd_t            algorithm_cmd,
	input logic                       cu_ready,
	input logic                       vertex_ready,
	input logic                       algorithm_ready,
	input logic                       write_grant,
	input cu_pkg::cu_cmd_t            read_command,
	input cu_pkg::cu_line_t           response_vertex,
	input cu_pkg::cu_line_t           response_algorithm,
	input cu_pkg::cu_line_t           data_0_vertex,
	input cu_pkg::cu_line_t           data_0_algorithm,
	input cu_pkg::cu_line_t           data_1_vertex,
	input cu_pkg::cu_line_t           data_1_algorithm,
	input logic [`CU_CONFIG_BITS-1:0] cu_status
);

	// one sticky flag per check, read by the testbench
	logic grant_overlap = 1'b0;
	logic grant_early   = 1'b0;
	logic read_blocked  = 1'b0;
	logic write_blocked = 1'b0;
	logic read_timing   = 1'b0;
	logic read_content  = 1'b0;
	logic lane_overlap  = 1'b0;
	logic status_moved  = 1'b0;
	logic any_fault;

	assign any_fault = grant_overlap | grant_early | read_blocked | write_blocked |
		read_timing | read_content | lane_overlap | status_moved;

	////////////////////
	// read arbitration

	assert property (@(posedge clock) disable iff (!rstn)
		!(vertex_ready && algorithm_ready))
	else begin
		grant_overlap = 1'b1;
		$error("both read clients granted in one cycle");
	end

	assert property (@(posedge clock) disable iff (!rstn)
		!cu_ready |-> !vertex_ready && !algorithm_ready)
	else begin
		grant_early = 1'b1;
		$error("read grant while the unit is not ready");
	end

	assert property (@(posedge clock) disable iff (!rstn)
		read_command.valid == $past(vertex_ready || algorithm_ready, 2))
	else begin
		read_timing = 1'b1;
		$error("read command not two cycles after its grant");
	end

	assert property (@(posedge clock) disable iff (!rstn)
		read_command.valid |->
			read_command.address == $past(algorithm_ready ? algorithm_cmd.address :
				vertex_cmd.address, 2) &&
			read_command.tag == $past(algorithm_ready ? algorithm_cmd.tag :
				vertex_cmd.tag, 2))
	else begin
		read_content = 1'b1;
		$error("read command differs from the granted client command");
	end

	////////////////////
	// back-pressure

	// pins high for two cycles have reached the latched flags
	assert property (@(posedge clock) disable iff (!rstn)
		$past(read_status.almost_full) && $past(read_status.almost_full, 2)
			|-> !vertex_ready && !algorithm_ready)
	else begin
		read_blocked = 1'b1;
		$error("read grant while the read buffer is almost full");
	end

	assert property (@(posedge clock) disable iff (!rstn)
		$past(write_status.almost_full) && $past(write_status.almost_full, 2)
			|-> !write_grant)
	else begin
		write_blocked = 1'b1;
		$error("write grant while the write buffer is almost full");
	end

	////////////////////
	// routing and status

	assert property (@(posedge clock) disable iff (!rstn)
		!(response_vertex.valid && response_algorithm.valid) &&
		!(data_0_vertex.valid && data_0_algorithm.valid) &&
		!(data_1_vertex.valid && data_1_algorithm.valid))
	else begin
		lane_overlap = 1'b1;
		$error("a lane is valid on both sides");
	end

	// a zero word leaves the latched configuration alone
	assert property (@(posedge clock) disable iff (!rstn)
		$past(config_word, 2) == '0 |-> $stable(cu_status))
	else begin
		status_moved = 1'b1;
		$error("status changed after a zero configuration word");
	end

endmodule

bind cu_control cu_control_assert checks (.*);

`default_nettype wire

// ==== dv/cu_control_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cu_macros.svh"

module cu_control_tb;

	import cu_pkg::*;

	logic                       clock;
	logic                       rstn;
	logic                       enable;
	logic [`CU_CONFIG_BITS-1:0] config_word;
	cu_job_t                    job;
	cu_status_t                 read_status;
	cu_status_t                 write_status;
	cu_line_t                   response;
	cu_line_t                   data_0;
	cu_line_t                   data_1;
	logic                       vertex_request;
	logic                       algorithm_request;
	cu_cmd_t                    vertex_cmd;
	cu_cmd_t                    algorithm_cmd;
	logic                       write_request;
	cu_cmd_t                    write_cmd;
	cu_line_t                   write_data_0_in;
	cu_line_t                   write_data_1_in;
	logic [`CU_VERTEX_BITS-1:0] vertex_done_count;
	logic [`CU_VERTEX_BITS-1:0] filtered_count;
	logic [`CU_EDGE_BITS-1:0]   edge_done_count;
	logic                       cu_ready;
	cu_line_t                   response_vertex;
	cu_line_t                   response_algorithm;
	cu_line_t                   data_0_vertex;
	cu_line_t                   data_0_algorithm;
	cu_line_t                   data_1_vertex;
	cu_line_t                   data_1_algorithm;
	logic                       vertex_ready;
	logic                       algorithm_ready;
	logic                       write_grant;
	cu_cmd_t                    read_command;
	cu_cmd_t                    write_command;
	cu_line_t                   write_data_0;
	cu_line_t                   write_data_1;
	cu_return_t                 cu_return;
	logic                       done;
	logic [`CU_CONFIG_BITS-1:0] cu_status;

	// reference state
	logic [15:0]                lfsr;
	logic [`CU_CONFIG_BITS-1:0] captured_config;
	logic                       enable_q = 1'b0;
	logic                       vertex_ready_q = 1'b0;
	logic                       algorithm_ready_q = 1'b0;
	logic                       ready_seen;
	logic                       served_any;
	logic                       last_served_algorithm;
	logic                       config_seen;
	logic                       job_seen;

	cu_control dut (.*);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	always @(posedge clock) begin
		enable_q          <= enable;
		vertex_ready_q    <= vertex_ready;
		algorithm_ready_q <= algorithm_ready;
	end

	always @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			ready_seen            <= 1'b0;
			served_any            <= 1'b0;
			last_served_algorithm <= 1'b0;
			config_seen           <= 1'b0;
			job_seen              <= 1'b0;
		end else begin
			if (cu_ready)
				ready_seen <= 1'b1;
			if (vertex_ready || algorithm_ready) begin
				served_any            <= 1'b1;
				last_served_algorithm <= algorithm_ready;
			end
			// configuration and job as taken in while enabled
			if (enable_q && config_word != '0)
				config_seen <= 1'b1;
			if (enable_q)
				job_seen <= job.valid;
		end
	end

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic report_error(input string msg);
		stop_with_failure($sformatf("ERROR at %0t ns: %s", $time, msg));
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit
	function automatic logic [63:0] take_bits(input int count);
		logic [63:0] value;
		logic        feedback;
		value = '0;
		for (int i = 0; i < count; i++) begin
			feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr     = {lfsr[14:0], feedback};
			value    = {value[62:0], feedback};
		end
		return value;
	endfunction

	function automatic cu_cmd_t random_cmd();
		cu_cmd_t cmd;
		cmd.valid   = 1'b1;
		cmd.tag     = `CU_TAG_BITS'(take_bits(`CU_TAG_BITS));
		cmd.address = take_bits(`CU_ADDR_BITS);
		return cmd;
	endfunction

	function automatic cu_line_t random_line();
		cu_line_t line;
		line.valid = 1'(take_bits(1));
		if (take_bits(1) != 0)
			line.tag = `CU_TAG_BITS'(`CU_VERTEX_CONTROL_ID);
		else
			line.tag = `CU_TAG_BITS'(take_bits(`CU_TAG_BITS));
		line.payload = take_bits(`CU_DATA_BITS);
		return line;
	endfunction

	// expected routing of one lane, two cycles after the line was sent
	function automatic logic lane_ok(input logic sent, input cu_line_t sent_line,
			input cu_line_t vertex_side, input cu_line_t algorithm_side);
		logic     to_vertex;
		cu_line_t chosen;
		to_vertex = sent_line.tag == `CU_TAG_BITS'(`CU_VERTEX_CONTROL_ID);
		chosen    = to_vertex ? vertex_side : algorithm_side;
		if (!sent)
			return !vertex_side.valid && !algorithm_side.valid;
		return chosen.valid && !(vertex_side.valid && algorithm_side.valid) &&
			chosen.tag == sent_line.tag && chosen.payload == sent_line.payload;
	endfunction

	// outbound write command, one cycle after it was sent while ready
	function automatic logic cmd_passed(input logic ready, input cu_cmd_t sent_cmd,
			input cu_cmd_t out_cmd);
		if (!(ready && sent_cmd.valid))
			return !out_cmd.valid;
		return out_cmd.valid && out_cmd.tag == sent_cmd.tag &&
			out_cmd.address == sent_cmd.address;
	endfunction

	// outbound write data lane, one cycle after it was sent while ready
	function automatic logic line_passed(input logic ready, input cu_line_t sent_line,
			input cu_line_t out_line);
		if (!(ready && sent_line.valid))
			return !out_line.valid;
		return out_line.valid && out_line.tag == sent_line.tag &&
			out_line.payload == sent_line.payload;
	endfunction

	////////////////////
	// checks

	assert property (@(posedge clock) disable iff (!rstn)
		cu_ready == (config_seen && job_seen))
	else report_error("cu_ready does not match the latched configuration and job");

	assert property (@(posedge clock) disable iff (!rstn)
		!cu_ready && !ready_seen |-> !(vertex_ready || algorithm_ready || write_grant ||
			read_command.valid || write_command.valid || write_data_0.valid ||
			write_data_1.valid || done))
	else report_error("output active before cu_ready");

	assert property (@(posedge clock) disable iff (!rstn)
		lane_ok($past(response.valid && enable && enable_q, 2), $past(response, 2),
			response_vertex, response_algorithm))
	else report_error("response lane routed wrongly");

	assert property (@(posedge clock) disable iff (!rstn)
		lane_ok($past(data_0.valid && enable && enable_q, 2), $past(data_0, 2),
			data_0_vertex, data_0_algorithm))
	else report_error("data_0 lane routed wrongly");

	assert property (@(posedge clock) disable iff (!rstn)
		lane_ok($past(data_1.valid && enable && enable_q, 2), $past(data_1, 2),
			data_1_vertex, data_1_algorithm))
	else report_error("data_1 lane routed wrongly");

	// most recently served client loses a tie
	assert property (@(posedge clock) disable iff (!rstn)
		vertex_request && algorithm_request && served_any &&
			(vertex_ready || algorithm_ready) |-> algorithm_ready != last_served_algorithm)
	else report_error("read grants did not alternate");

	assert property (@(posedge clock) disable iff (!rstn)
		write_grant == ($past(cu_ready && write_request) &&
			!$past(write_status.almost_full, 2)))
	else report_error("write_grant does not follow write_request");

	assert property (@(posedge clock) disable iff (!rstn)
		cmd_passed($past(cu_ready), $past(write_cmd), write_command))
	else report_error("write_command does not follow write_cmd");

	assert property (@(posedge clock) disable iff (!rstn)
		line_passed($past(cu_ready), $past(write_data_0_in), write_data_0))
	else report_error("write_data_0 does not follow write_data_0_in");

	assert property (@(posedge clock) disable iff (!rstn)
		line_passed($past(cu_ready), $past(write_data_1_in), write_data_1))
	else report_error("write_data_1 does not follow write_data_1_in");

	assert property (@(posedge clock) disable iff (!rstn)
		done == $past(cu_ready && job.valid &&
			(vertex_done_count + filtered_count == job.num_vertices) &&
			(edge_done_count == job.num_edges), 4))
	else report_error("done not four cycles after matching counts");

	assert property (@(posedge clock) disable iff (!rstn)
		done |-> cu_return.vertex_total == $past(vertex_done_count + filtered_count, 4) &&
			cu_return.edge_total == $past(edge_done_count, 4) &&
			cu_status == captured_config)
	else report_error("wrong return values or status with done");

	always @(negedge clock) begin
		if (dut.checks.any_fault)
			report_error("bound assertion in cu_control_assert failed");
	end

	////////////////////
	// stimulus

	task automatic next_cycle();
		@(posedge clock);
		#2;
	endtask

	task automatic wait_for_ready(input int limit);
		for (int i = 0; i < limit; i++) begin
			if (cu_ready)
				return;
			next_cycle();
		end
		stop_with_failure("timeout: cu_ready never rose after configuration");
	endtask

	task automatic wait_for_done(input int limit);
		for (int i = 0; i < limit; i++) begin
			if (done)
				return;
			next_cycle();
		end
		stop_with_failure("timeout: done never rose after matching counts");
	endtask

	task automatic send_lines(input int cycles);
		for (int i = 0; i < cycles; i++) begin
			next_cycle();
			response = random_line();
			data_0   = random_line();
			data_1   = random_line();
		end
		next_cycle();
		response = '0;
		data_0   = '0;
		data_1   = '0;
	endtask

	task automatic run_requests(input int cycles, input logic pressure);
		for (int i = 0; i < cycles; i++) begin
			next_cycle();
			// a served client moves on to its next command
			if (vertex_ready_q)
				vertex_cmd = random_cmd();
			if (algorithm_ready_q)
				algorithm_cmd = random_cmd();
			if (pressure) begin
				vertex_request           = 1'(take_bits(1));
				algorithm_request        = 1'(take_bits(1));
				read_status.almost_full  = 1'(take_bits(1));
				write_status.almost_full = 1'(take_bits(1));
				write_request            = 1'(take_bits(1));
			end else begin
				vertex_request    = 1'b1;
				algorithm_request = 1'b1;
				write_request     = 1'b1;
			end
			write_cmd       = random_cmd();
			write_cmd.valid = write_request;
			write_data_0_in = random_line();
			write_data_1_in = random_line();
		end
	endtask

	initial begin
		lfsr              = 16'd62139;
		rstn              = 1'b0;
		enable            = 1'b0;
		config_word       = '0;
		job               = '0;
		read_status       = '{almost_full: 1'b0, empty: 1'b1};
		write_status      = '{almost_full: 1'b0, empty: 1'b1};
		response          = '0;
		data_0            = '0;
		data_1            = '0;
		vertex_request    = 1'b0;
		algorithm_request = 1'b0;
		vertex_cmd        = '0;
		algorithm_cmd     = '0;
		write_request     = 1'b0;
		write_cmd         = '0;
		write_data_0_in   = '0;
		write_data_1_in   = '0;
		vertex_done_count = '0;
		filtered_count    = '0;
		edge_done_count   = '0;
		captured_config   = '0;
		repeat (4) @(posedge clock);
		#2;
		rstn = 1'b1;

		// valid job and active clients, but no configuration yet
		enable           = 1'b1;
		job.valid        = 1'b1;
		job.num_vertices = 32'(take_bits(20)) | 32'd1;
		job.num_edges    = 32'(take_bits(20)) | 32'd1;
		vertex_request    = 1'b1;
		algorithm_request = 1'b1;
		vertex_cmd        = random_cmd();
		algorithm_cmd     = random_cmd();
		write_request     = 1'b1;
		write_cmd         = random_cmd();
		repeat (8) next_cycle();
		vertex_request    = 1'b0;
		algorithm_request = 1'b0;
		write_request     = 1'b0;
		write_cmd.valid   = 1'b0;
		config_word       = take_bits(`CU_CONFIG_BITS) | 64'd1;
		captured_config   = config_word;
		next_cycle();
		config_word = '0;
		wait_for_ready(10);

		send_lines(40);
		run_requests(16, 1'b0);
		run_requests(48, 1'b1);
		next_cycle();
		vertex_request           = 1'b0;
		algorithm_request        = 1'b0;
		write_request            = 1'b0;
		write_cmd.valid          = 1'b0;
		write_data_0_in          = '0;
		write_data_1_in          = '0;
		read_status.almost_full  = 1'b0;
		write_status.almost_full = 1'b0;
		repeat (4) next_cycle();

		// counts meet the descriptor for one cycle
		vertex_done_count = 32'(take_bits(16));
		filtered_count    = job.num_vertices - vertex_done_count;
		edge_done_count   = job.num_edges;
		next_cycle();
		vertex_done_count = '0;
		filtered_count    = '0;
		edge_done_count   = '0;
		wait_for_done(12);
		repeat (4) next_cycle();

		if (dut.checks.any_fault)
			report_error("bound assertion in cu_control_assert failed");
		else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the cu_control testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f \
	--top-module cu_control_tb -o cu_control_sim

# keep running past assertion errors so the testbench reports them
result=$(./obj_dir/cu_control_sim +verilator+error+limit+100 || true)
echo "$result"

echo "$result" | grep -qx '>>> PASS'

// ==== src/cu_command_output.sv ====
`default_nettype none
`timescale 1ns/1ps

module cu_command_output (
	input  logic               clock,
	input  logic               rstn,
	input  logic               cu_ready,
	input  cu_pkg::cu_status_t write_status,
	input  logic               write_request,
	input  cu_pkg::cu_cmd_t    granted_cmd,
	input  cu_pkg::cu_cmd_t    write_cmd,
	input  cu_pkg::cu_line_t   write_data_0_in,
	input  cu_pkg::cu_line_t   write_data_1_in,
	output logic               write_grant,
	output cu_pkg::cu_cmd_t    read_command,
	output cu_pkg::cu_cmd_t    write_command,
	output cu_pkg::cu_line_t   write_data_0,
	output cu_pkg::cu_line_t   write_data_1
);

	import cu_pkg::*;

	logic     read_valid;
	logic     write_valid;
	logic     data_0_valid;
	logic     data_1_valid;
	cu_cmd_t  read_q;
	cu_cmd_t  write_q;
	cu_line_t data_0_q;
	cu_line_t data_1_q;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_grant  <= 1'b0;
			read_valid   <= 1'b0;
			write_valid  <= 1'b0;
			data_0_valid <= 1'b0;
			data_1_valid <= 1'b0;
		end else begin
			// held off while the write buffer is almost full
			write_grant  <= cu_ready && write_request && !write_status.almost_full;
			read_valid   <= cu_ready && granted_cmd.valid;
			write_valid  <= cu_ready && write_cmd.valid;
			data_0_valid <= cu_ready && write_data_0_in.valid;
			data_1_valid <= cu_ready && write_data_1_in.valid;
		end
	end

	always_ff @(posedge clock) begin
		read_q   <= granted_cmd;
		write_q  <= write_cmd;
		data_0_q <= write_data_0_in;
		data_1_q <= write_data_1_in;
	end

	assign read_command  = '{valid: read_valid, tag: read_q.tag, address: read_q.address};
	assign write_command = '{valid: write_valid, tag: write_q.tag, address: write_q.address};
	assign write_data_0  = '{valid: data_0_valid, tag: data_0_q.tag, payload: data_0_q.payload};
	assign write_data_1  = '{valid: data_1_valid, tag: data_1_q.tag, payload: data_1_q.payload};

endmodule

`default_nettype wire

// ==== src/cu_control.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cu_macros.svh"

module cu_control (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       enable,
	input  logic [`CU_CONFIG_BITS-1:0] config_word,
	input  cu_pkg::cu_job_t            job,
	input  cu_pkg::cu_status_t         read_status,
	input  cu_pkg::cu_status_t         write_status,
	input  cu_pkg::cu_line_t           response,
	input  cu_pkg::cu_line_t           data_0,
	input  cu_pkg::cu_line_t           data_1,
	input  logic                       vertex_request,
	input  logic                       algorithm_request,
	input  cu_pkg::cu_cmd_t            vertex_cmd,
	input  cu_pkg::cu_cmd_t            algorithm_cmd,
	input  logic                       write_request,
	input  cu_pkg::cu_cmd_t            write_cmd,
	input  cu_pkg::cu_line_t           write_data_0_in,
	input  cu_pkg::cu_line_t           write_data_1_in,
	input  logic [`CU_VERTEX_BITS-1:0] vertex_done_count,
	input  logic [`CU_VERTEX_BITS-1:0] filtered_count,
	input  logic [`CU_EDGE_BITS-1:0]   edge_done_count,
	output logic                       cu_ready,
	output cu_pkg::cu_line_t           response_vertex,
	output cu_pkg::cu_line_t           response_algorithm,
	output cu_pkg::cu_line_t           data_0_vertex,
	output cu_pkg::cu_line_t           data_0_algorithm,
	output cu_pkg::cu_line_t           data_1_vertex,
	output cu_pkg::cu_line_t           data_1_algorithm,
	output logic                       vertex_ready,
	output logic                       algorithm_ready,
	output logic                       write_grant,
	output cu_pkg::cu_cmd_t            read_command,
	output cu_pkg::cu_cmd_t            write_command,
	output cu_pkg::cu_line_t           write_data_0,
	output cu_pkg::cu_line_t           write_data_1,
	output cu_pkg::cu_return_t         cu_return,
	output logic                       done,
	output logic [`CU_CONFIG_BITS-1:0] cu_status
);

	import cu_pkg::*;

	logic                       enabled;
	logic [`CU_CONFIG_BITS-1:0] config_latched;
	cu_job_t                    job_latched;
	cu_status_t                 read_status_latched;
	cu_status_t                 write_status_latched;
	cu_line_t                   response_latched;
	cu_line_t                   data_0_latched;
	cu_line_t                   data_1_latched;
	cu_cmd_t                    granted_cmd;

	////////////////////
	// inbound

	cu_input_stage input_stage (
		.clock               (clock),
		.rstn                (rstn),
		.enable              (enable),
		.config_word         (config_word),
		.job                 (job),
		.read_status         (read_status),
		.write_status        (write_status),
		.response            (response),
		.data_0              (data_0),
		.data_1              (data_1),
		.enabled             (enabled),
		.cu_ready            (cu_ready),
		.config_latched      (config_latched),
		.job_latched         (job_latched),
		.read_status_latched (read_status_latched),
		.write_status_latched(write_status_latched),
		.response_latched    (response_latched),
		.data_0_latched      (data_0_latched),
		.data_1_latched      (data_1_latched)
	);

	// one router per tagged lane
	cu_response_router router_response (
		.clock         (clock),
		.rstn          (rstn),
		.enabled       (enabled),
		.line          (response_latched),
		.vertex_line   (response_vertex),
		.algorithm_line(response_algorithm)
	);

	cu_response_router router_data_0 (
		.clock         (clock),
		.rstn          (rstn),
		.enabled       (enabled),
		.line          (data_0_latched),
		.vertex_line   (data_0_vertex),
		.algorithm_line(data_0_algorithm)
	);

	cu_response_router router_data_1 (
		.clock         (clock),
		.rstn          (rstn),
		.enabled       (enabled),
		.line          (data_1_latched),
		.vertex_line   (data_1_vertex),
		.algorithm_line(data_1_algorithm)
	);

	////////////////////
	// outbound commands

	cu_read_arbiter read_arbiter (
		.clock            (clock),
		.rstn             (rstn),
		.cu_ready         (cu_ready),
		.read_status      (read_status_latched),
		.vertex_request   (vertex_request),
		.algorithm_request(algorithm_request),
		.vertex_cmd       (vertex_cmd),
		.algorithm_cmd    (algorithm_cmd),
		.vertex_ready     (vertex_ready),
		.algorithm_ready  (algorithm_ready),
		.granted_cmd      (granted_cmd)
	);

	cu_command_output command_output (
		.clock          (clock),
		.rstn           (rstn),
		.cu_ready       (cu_ready),
		.write_status   (write_status_latched),
		.write_request  (write_request),
		.granted_cmd    (granted_cmd),
		.write_cmd      (write_cmd),
		.write_data_0_in(write_data_0_in),
		.write_data_1_in(write_data_1_in),
		.write_grant    (write_grant),
		.read_command   (read_command),
		.write_command  (write_command),
		.write_data_0   (write_data_0),
		.write_data_1   (write_data_1)
	);

	////////////////////
	// completion

	cu_job_tracker job_tracker (
		.clock            (clock),
		.rstn             (rstn),
		.enabled          (enabled),
		.cu_ready         (cu_ready),
		.job_latched      (job_latched),
		.config_latched   (config_latched),
		.vertex_done_count(vertex_done_count),
		.filtered_count   (filtered_count),
		.edge_done_count  (edge_done_count),
		.cu_return        (cu_return),
		.done             (done),
		.status           (cu_status)
	);

endmodule

`default_nettype wire

// ==== src/cu_input_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cu_macros.svh"

module cu_input_stage (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       enable,
	input  logic [`CU_CONFIG_BITS-1:0] config_word,
	input  cu_pkg::cu_job_t            job,
	input  cu_pkg::cu_status_t         read_status,
	input  cu_pkg::cu_status_t         write_status,
	input  cu_pkg::cu_line_t           response,
	input  cu_pkg::cu_line_t           data_0,
	input  cu_pkg::cu_line_t           data_1,
	output logic                       enabled,
	output logic                       cu_ready,
	output logic [`CU_CONFIG_BITS-1:0] config_latched,
	output cu_pkg::cu_job_t            job_latched,
	output cu_pkg::cu_status_t         read_status_latched,
	output cu_pkg::cu_status_t         write_status_latched,
	output cu_pkg::cu_line_t           response_latched,
	output cu_pkg::cu_line_t           data_0_latched,
	output cu_pkg::cu_line_t           data_1_latched
);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled              <= 1'b0;
			config_latched       <= '0;
			job_latched          <= '0;
			read_status_latched  <= '{almost_full: 1'b0, empty: 1'b1};
			write_status_latched <= '{almost_full: 1'b0, empty: 1'b1};
			response_latched     <= '0;
			data_0_latched       <= '0;
			data_1_latched       <= '0;
		end else begin
			enabled <= enable;
			// inbound pulses are dropped while disabled
			response_latched <= response;
			data_0_latched   <= data_0;
			data_1_latched   <= data_1;
			response_latched.valid <= enabled && response.valid;
			data_0_latched.valid   <= enabled && data_0.valid;
			data_1_latched.valid   <= enabled && data_1.valid;
			if (enabled) begin
				job_latched          <= job;
				read_status_latched  <= read_status;
				write_status_latched <= write_status;
				// a zero word means no new configuration
				if (|config_word)
					config_latched <= config_word;
			end
		end
	end

	assign cu_ready = (|config_latched) && job_latched.valid;

endmodule

`default_nettype wire

// ==== src/cu_job_tracker.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cu_macros.svh"

module cu_job_tracker (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       enabled,
	input  logic                       cu_ready,
	input  cu_pkg::cu_job_t            job_latched,
	input  logic [`CU_CONFIG_BITS-1:0] config_latched,
	input  logic [`CU_VERTEX_BITS-1:0] vertex_done_count,
	input  logic [`CU_VERTEX_BITS-1:0] filtered_count,
	input  logic [`CU_EDGE_BITS-1:0]   edge_done_count,
	output cu_pkg::cu_return_t         cu_return,
	output logic                       done,
	output logic [`CU_CONFIG_BITS-1:0] status
);

	import cu_pkg::*;

	logic [`CU_VERTEX_BITS-1:0] vertex_done_q;
	logic [`CU_VERTEX_BITS-1:0] filtered_q;
	logic [`CU_EDGE_BITS-1:0]   edge_done_q;
	logic [`CU_VERTEX_BITS-1:0] vertex_total;
	logic [`CU_EDGE_BITS-1:0]   edge_total;
	logic                       totals_match;
	cu_return_t                 return_q;

	////////////////////
	// count pipeline

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_done_q <= '0;
			filtered_q    <= '0;
			edge_done_q   <= '0;
			vertex_total  <= '0;
			edge_total    <= '0;
			totals_match  <= 1'b0;
			return_q      <= '0;
		end else if (cu_ready) begin
			vertex_done_q <= vertex_done_count;
			filtered_q    <= filtered_count;
			edge_done_q   <= edge_done_count;
			// zero-degree vertices count as processed
			vertex_total  <= vertex_done_q + filtered_q;
			edge_total    <= edge_done_q;
			totals_match  <= job_latched.valid &&
				(vertex_total == job_latched.num_vertices) &&
				(edge_total == job_latched.num_edges);
			return_q      <= '{vertex_total: vertex_total, edge_total: edge_total};
		end
	end

	////////////////////
	// outputs

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_return <= '0;
			done      <= 1'b0;
			status    <= '0;
		end else if (enabled) begin
			cu_return <= return_q;
			done      <= totals_match;
			status    <= config_latched;
		end
	end

endmodule

`default_nettype wire

// ==== src/cu_macros.svh ====
`ifndef CU_MACROS_SVH
`define CU_MACROS_SVH

// job descriptor counts
`define CU_VERTEX_BITS 32
`define CU_EDGE_BITS 32

// command address and data line payload
`define CU_ADDR_BITS 64
`define CU_DATA_BITS 64

// compute-unit id carried on every line and command
`define CU_TAG_BITS 8

// configuration word, also mirrored out as status
`define CU_CONFIG_BITS 64

// tag value owned by the vertex-job client
`define CU_VERTEX_CONTROL_ID 0

`endif

// ==== src/cu_pkg.sv ====
`default_nettype none

`include "cu_macros.svh"

package cu_pkg;

	// job descriptor, valid once the host has written it
	typedef struct packed {
		logic                       valid;
		logic [`CU_VERTEX_BITS-1:0] num_vertices;
		logic [`CU_EDGE_BITS-1:0]   num_edges;
	} cu_job_t;

	// read response and read/write data lanes
	typedef struct packed {
		logic                     valid;
		logic [`CU_TAG_BITS-1:0]  tag;
		logic [`CU_DATA_BITS-1:0] payload;
	} cu_line_t;

	// read or write command toward the memory side
	typedef struct packed {
		logic                     valid;
		logic [`CU_TAG_BITS-1:0]  tag;
		logic [`CU_ADDR_BITS-1:0] address;
	} cu_cmd_t;

	// buffer occupancy flags
	typedef struct packed {
		logic almost_full;
		logic empty;
	} cu_status_t;

	// totals handed back with done
	typedef struct packed {
		logic [`CU_VERTEX_BITS-1:0] vertex_total;
		logic [`CU_EDGE_BITS-1:0]   edge_total;
	} cu_return_t;

endpackage

`default_nettype wire

// ==== src/cu_read_arbiter.sv ====
`default_nettype none
`timescale 1ns/1ps

module cu_read_arbiter (
	input  logic               clock,
	input  logic               rstn,
	input  logic               cu_ready,
	input  cu_pkg::cu_status_t read_status,
	input  logic               vertex_request,
	input  logic               algorithm_request,
	input  cu_pkg::cu_cmd_t    vertex_cmd,
	input  cu_pkg::cu_cmd_t    algorithm_cmd,
	output logic               vertex_ready,
	output logic               algorithm_ready,
	output cu_pkg::cu_cmd_t    granted_cmd
);

	import cu_pkg::*;

	logic    grant_open;
	logic    grant_vertex;
	logic    grant_algorithm;
	// high when the algorithm side won last
	logic    last_algorithm;
	logic    cmd_valid;
	cu_cmd_t winner_q;

	////////////////////
	// grant decision

	assign grant_open = cu_ready && !read_status.almost_full;

	always_comb begin
		grant_vertex    = 1'b0;
		grant_algorithm = 1'b0;
		if (grant_open) begin
			if (vertex_request && algorithm_request) begin
				// last served loses the tie
				grant_vertex    = last_algorithm;
				grant_algorithm = !last_algorithm;
			end else begin
				grant_vertex    = vertex_request;
				grant_algorithm = algorithm_request;
			end
		end
	end

	assign vertex_ready    = grant_vertex;
	assign algorithm_ready = grant_algorithm;

	////////////////////
	// pointer and command register

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			last_algorithm <= 1'b1;
			cmd_valid      <= 1'b0;
		end else begin
			cmd_valid <= grant_vertex || grant_algorithm;
			if (grant_vertex || grant_algorithm)
				last_algorithm <= grant_algorithm;
		end
	end

	always_ff @(posedge clock) begin
		winner_q <= grant_algorithm ? algorithm_cmd : vertex_cmd;
	end

	assign granted_cmd = '{valid: cmd_valid, tag: winner_q.tag, address: winner_q.address};

endmodule

`default_nettype wire

// ==== src/cu_response_router.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "cu_macros.svh"

module cu_response_router (
	input  logic             clock,
	input  logic             rstn,
	input  logic             enabled,
	input  cu_pkg::cu_line_t line,
	output cu_pkg::cu_line_t vertex_line,
	output cu_pkg::cu_line_t algorithm_line
);

	import cu_pkg::*;

	logic     vertex_valid;
	logic     algorithm_valid;
	logic     to_vertex;
	cu_line_t line_q;

	// tag decode
	assign to_vertex = (line.tag == `CU_TAG_BITS'(`CU_VERTEX_CONTROL_ID));

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_valid    <= 1'b0;
			algorithm_valid <= 1'b0;
		end else begin
			vertex_valid    <= enabled && line.valid && to_vertex;
			algorithm_valid <= enabled && line.valid && !to_vertex;
		end
	end

	// tag and payload go to both sides, only one valid
	always_ff @(posedge clock) begin
		line_q <= line;
	end

	assign vertex_line = '{
		valid:   vertex_valid,
		tag:     line_q.tag,
		payload: line_q.payload
	};

	assign algorithm_line = '{
		valid:   algorithm_valid,
		tag:     line_q.tag,
		payload: line_q.payload
	};

endmodule

`default_nettype wire
